// File: Makefile
VERILATOR  ?= verilator
COMMON     := --timing --timescale 1ns/10ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert -j 0 $(COMMON)
TOP        := tb_cnn
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
rtl/cnn_pkg.sv
rtl/cnn_ifs.sv
rtl/input_store.sv
rtl/conv_engine.sv
rtl/fmap_buffer.sv
rtl/max_pool.sv
rtl/cnn_top.sv
test/tb_cnn.sv

// File: rtl/cnn_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// ====================
// Window request and reply
// ====================
interface window_if import cnn_pkg::*; #(
    parameter int PIX_W = 8
) ();
    // Output position asked for by the engine
    chan_t  ch;
    coord_t row;
    coord_t col;

    // Padded pixels, taps ordered TL, TR, BL, BR
    logic signed [PIX_W-1:0] pix  [KER_TAPS];
    logic signed [PIX_W-1:0] tap1 [KER_TAPS];
    logic signed [PIX_W-1:0] tap2 [KER_TAPS];
    logic                    loaded;

    modport source (input ch, row, col, output pix, tap1, tap2, loaded);
    modport sink   (output ch, row, col, input pix, tap1, tap2, loaded);
endinterface

// ====================
// Feature map write and read
// ====================
interface fmap_if import cnn_pkg::*; #(
    parameter int ACC_W = 20
) ();
    logic                    wr_en;
    logic                    wr_first;
    logic                    wr_last;
    fmap_addr_t              wr_addr;
    logic signed [ACC_W-1:0] wr_data [OUT_CH];

    logic                    filled;
    fmap_addr_t              rd_addr;
    logic signed [ACC_W-1:0] rd_data [OUT_CH];

    modport writer (output wr_en, wr_first, wr_last, wr_addr, wr_data);
    modport buffer (input wr_en, wr_first, wr_last, wr_addr, wr_data, rd_addr,
                    output filled, rd_data);
    modport reader (input filled, rd_data, output rd_addr);
endinterface

`default_nettype wire

// File: rtl/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // ====================
    // Geometry
    // ====================
    localparam int IMG_DIM  = 5;
    localparam int PAD_DIM  = IMG_DIM + 2;
    localparam int KER_DIM  = 2;
    localparam int KER_TAPS = KER_DIM * KER_DIM;
    localparam int CONV_DIM = PAD_DIM - KER_DIM + 1;
    localparam int IN_CH    = 3;
    localparam int OUT_CH   = 2;
    localparam int POOL_WIN = 3;
    localparam int POOL_DIM = CONV_DIM / POOL_WIN;

    // Input burst layout
    localparam int PIX_PER_CH  = IMG_DIM * IMG_DIM;
    localparam int LOAD_CYCLES = IN_CH * PIX_PER_CH;
    localparam int KER_CYCLES  = IN_CH * KER_TAPS;

    // ====================
    // Types
    // ====================
    typedef logic signed [7:0]  pix_t;
    typedef logic signed [19:0] acc_t;
    typedef logic [2:0]         coord_t;
    typedef logic [1:0]         chan_t;
    typedef logic [5:0]         fmap_addr_t;

    typedef enum logic [1:0] {CONV_IDLE, CONV_RUN, CONV_DRAIN} conv_state_t;
    typedef enum logic [1:0] {POOL_IDLE, POOL_SCAN, POOL_OUT}  pool_state_t;

endpackage

`default_nettype wire

// File: rtl/cnn_top.sv
`timescale 1ns/10ps
`default_nettype none

module cnn_top import cnn_pkg::*; #(
    parameter int PIX_W = 8,
    parameter int ACC_W = 20
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       in_valid,
    input  wire pix_t img,
    input  wire pix_t kernel_ch1,
    input  wire pix_t kernel_ch2,
    input  wire       opt,
    output logic      out_valid,
    output acc_t      out
);

    // ====================
    // Internal buses
    // ====================
    window_if #(.PIX_W(PIX_W)) win_bus ();
    fmap_if   #(.ACC_W(ACC_W)) fm_bus ();

    // Capture and padding
    input_store #(.PIX_W(PIX_W)) u_input_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .img        (img),
        .kernel_ch1 (kernel_ch1),
        .kernel_ch2 (kernel_ch2),
        .opt        (opt),
        .win        (win_bus.source)
    );

    // Producer
    conv_engine #(.PIX_W(PIX_W), .ACC_W(ACC_W)) u_conv_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .win   (win_bus.sink),
        .fm    (fm_bus.writer)
    );

    // Two 6x6 maps
    fmap_buffer #(.ACC_W(ACC_W)) u_fmap_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .fm    (fm_bus.buffer)
    );

    // Consumer
    max_pool #(.ACC_W(ACC_W)) u_max_pool (
        .clk       (clk),
        .rst_n     (rst_n),
        .fm        (fm_bus.reader),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

`default_nettype wire

// File: rtl/conv_engine.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine import cnn_pkg::*; #(
    parameter int PIX_W = 8,
    parameter int ACC_W = 20
) (
    input  wire      clk,
    input  wire      rst_n,
    window_if.sink   win,
    fmap_if.writer   fm
);
    typedef logic signed [ACC_W-1:0] accw_t;

    conv_state_t state;
    chan_t       ch;
    coord_t      row;
    coord_t      col;
    logic        pos_last;
    logic        running;
    accw_t       sum [OUT_CH];

    assign win.ch  = ch;
    assign win.row = row;
    assign win.col = col;

    assign running  = (state == CONV_RUN);
    assign pos_last = (ch == chan_t'(IN_CH - 1)) &&
                      (row == coord_t'(CONV_DIM - 1)) &&
                      (col == coord_t'(CONV_DIM - 1));

    // ====================
    // Position sequencer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CONV_IDLE;
            ch    <= '0;
            row   <= '0;
            col   <= '0;
        end else begin
            case (state)
                CONV_IDLE: begin
                    ch  <= '0;
                    row <= '0;
                    col <= '0;
                    if (win.loaded) begin
                        state <= CONV_RUN;
                    end
                end
                CONV_RUN: begin
                    if (pos_last) begin
                        state <= CONV_DRAIN;
                    end else if (col == coord_t'(CONV_DIM - 1)) begin
                        col <= '0;
                        if (row == coord_t'(CONV_DIM - 1)) begin
                            row <= '0;
                            ch  <= ch + chan_t'(1);
                        end else begin
                            row <= row + coord_t'(1);
                        end
                    end else begin
                        col <= col + coord_t'(1);
                    end
                end
                // Last sum still in the output register
                default: state <= CONV_IDLE;
            endcase
        end
    end

    // Eight products, two 4-term sums
    always_comb begin
        sum[0] = '0;
        sum[1] = '0;
        for (int t = 0; t < KER_TAPS; t++) begin
            sum[0] = sum[0] + ACC_W'(win.pix[t]) * ACC_W'(win.tap1[t]);
            sum[1] = sum[1] + ACC_W'(win.pix[t]) * ACC_W'(win.tap2[t]);
        end
    end

    // ====================
    // Write register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm.wr_en    <= 1'b0;
            fm.wr_first <= 1'b0;
            fm.wr_last  <= 1'b0;
        end else begin
            fm.wr_en    <= running;
            fm.wr_first <= running && (ch == '0);
            fm.wr_last  <= running && pos_last;
        end
    end

    always_ff @(posedge clk) begin
        fm.wr_addr    <= fmap_addr_t'(row * CONV_DIM + col);
        fm.wr_data[0] <= sum[0];
        fm.wr_data[1] <= sum[1];
    end

    // A new job must not arrive mid-run
    assert property (@(posedge clk) disable iff (!rst_n)
        win.loaded |-> state == CONV_IDLE)
        else $error("input loaded while the engine was still running");

endmodule

`default_nettype wire

// File: rtl/fmap_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fmap_buffer import cnn_pkg::*; #(
    parameter int ACC_W = 20
) (
    input  wire    clk,
    input  wire    rst_n,
    fmap_if.buffer fm
);
    localparam int MAP_SIZE = CONV_DIM * CONV_DIM;

    typedef logic signed [ACC_W-1:0] accw_t;

    accw_t map [OUT_CH][MAP_SIZE];

    // ====================
    // Accumulate and read
    // ====================
    // Channel 0 overwrites, later channels add on top
    always_ff @(posedge clk) begin
        for (int o = 0; o < OUT_CH; o++) begin
            if (fm.wr_en) begin
                if (fm.wr_first) begin
                    map[o][fm.wr_addr] <= fm.wr_data[o];
                end else begin
                    map[o][fm.wr_addr] <= map[o][fm.wr_addr] + fm.wr_data[o];
                end
            end
        end
    end

    // Both maps at the same address, one cycle later
    always_ff @(posedge clk) begin
        for (int o = 0; o < OUT_CH; o++) begin
            fm.rd_data[o] <= map[o][fm.rd_addr];
        end
    end

    // Maps complete once the last write lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm.filled <= 1'b0;
        end else begin
            fm.filled <= fm.wr_en && fm.wr_last;
        end
    end

endmodule

`default_nettype wire

// File: rtl/input_store.sv
`timescale 1ns/10ps
`default_nettype none

module input_store import cnn_pkg::*; #(
    parameter int PIX_W = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          in_valid,
    input  wire logic signed [PIX_W-1:0] img,
    input  wire logic signed [PIX_W-1:0] kernel_ch1,
    input  wire logic signed [PIX_W-1:0] kernel_ch2,
    input  wire                          opt,
    window_if.source                     win
);
    typedef logic signed [PIX_W-1:0] pixw_t;

    logic [6:0] cnt;
    logic       busy;
    logic       mode;
    logic       last_in;

    pixw_t pix_mem  [LOAD_CYCLES];
    pixw_t tap1_mem [KER_CYCLES];
    pixw_t tap2_mem [KER_CYCLES];

    assign last_in = in_valid && (cnt == 7'(LOAD_CYCLES - 1));

    // ====================
    // Burst control
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            busy       <= 1'b0;
            mode       <= 1'b0;
            win.loaded <= 1'b0;
        end else begin
            if (in_valid) begin
                cnt <= last_in ? '0 : cnt + 7'd1;
            end
            // Mode is taken on the first beat only
            if (in_valid && !busy) begin
                busy <= 1'b1;
                mode <= opt;
            end else if (win.loaded) begin
                busy <= 1'b0;
            end
            win.loaded <= last_in;
        end
    end

    // Pixels in arrival order, channel major
    always_ff @(posedge clk) begin
        if (in_valid) begin
            pix_mem[cnt] <= img;
            if (cnt < 7'(KER_CYCLES)) begin
                tap1_mem[cnt[3:0]] <= kernel_ch1;
                tap2_mem[cnt[3:0]] <= kernel_ch2;
            end
        end
    end

    // Padded coordinate to image coordinate, edges clamp
    function automatic coord_t img_coord(input coord_t p);
        if (p == '0) return '0;
        if (p == coord_t'(PAD_DIM - 1)) return coord_t'(IMG_DIM - 1);
        return p - coord_t'(1);
    endfunction

    // ====================
    // Window lookup
    // ====================
    always_comb begin
        coord_t     pr;
        coord_t     pc;
        logic       border;
        logic [6:0] idx;
        for (int t = 0; t < KER_TAPS; t++) begin
            pr = win.row + coord_t'(t / KER_DIM);
            pc = win.col + coord_t'(t % KER_DIM);
            border = (pr == '0) || (pc == '0) ||
                     (pr == coord_t'(PAD_DIM - 1)) || (pc == coord_t'(PAD_DIM - 1));
            idx = 7'(win.ch) * 7'(PIX_PER_CH) + 7'(img_coord(pr)) * 7'(IMG_DIM)
                + 7'(img_coord(pc));
            // Zero mode blanks the ring, replicate mode reads the clamped pixel
            win.pix[t]  = (border && !mode) ? '0 : pix_mem[idx];
            win.tap1[t] = tap1_mem[4'(win.ch) * 4'(KER_TAPS) + 4'(t)];
            win.tap2[t] = tap2_mem[4'(win.ch) * 4'(KER_TAPS) + 4'(t)];
        end
    end

    // A burst runs its full length without gaps
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !last_in |=> in_valid)
        else $error("in_valid dropped inside an input burst");

    // New burst only once the previous one has been handed over
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_valid) |-> !busy)
        else $error("in_valid started while the store was busy");

endmodule

`default_nettype wire

// File: rtl/max_pool.sv
`timescale 1ns/10ps
`default_nettype none

module max_pool import cnn_pkg::*; #(
    parameter int ACC_W = 20
) (
    input  wire                     clk,
    input  wire                     rst_n,
    fmap_if.reader                  fm,
    output logic                    out_valid,
    output logic signed [ACC_W-1:0] out
);
    localparam int WIN_PER_CH = POOL_DIM * POOL_DIM;
    localparam int N_MAX      = OUT_CH * WIN_PER_CH;

    typedef logic signed [ACC_W-1:0] accw_t;

    pool_state_t state;
    coord_t      row;
    coord_t      col;
    logic        scan_last;
    logic        d_vld;
    coord_t      d_row;
    coord_t      d_col;
    logic [1:0]  win_sel;
    logic        win_first;
    logic [2:0]  out_idx;
    accw_t       maxv [N_MAX];

    assign fm.rd_addr = fmap_addr_t'(row * CONV_DIM + col);
    assign scan_last  = (row == coord_t'(CONV_DIM - 1)) && (col == coord_t'(CONV_DIM - 1));

    // Window of the value now on rd_data
    assign win_sel   = {d_row >= coord_t'(POOL_WIN), d_col >= coord_t'(POOL_WIN)};
    assign win_first = (d_row == '0 || d_row == coord_t'(POOL_WIN)) &&
                       (d_col == '0 || d_col == coord_t'(POOL_WIN));

    // ====================
    // Scan and output FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= POOL_IDLE;
            row       <= '0;
            col       <= '0;
            d_vld     <= 1'b0;
            d_row     <= '0;
            d_col     <= '0;
            out_idx   <= '0;
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            d_vld     <= (state == POOL_SCAN);
            d_row     <= row;
            d_col     <= col;
            out_valid <= (state == POOL_OUT);
            out       <= (state == POOL_OUT) ? maxv[out_idx] : '0;
            case (state)
                POOL_IDLE: begin
                    row     <= '0;
                    col     <= '0;
                    out_idx <= '0;
                    if (fm.filled) begin
                        state <= POOL_SCAN;
                    end
                end
                POOL_SCAN: begin
                    if (scan_last) begin
                        state <= POOL_OUT;
                    end else if (col == coord_t'(CONV_DIM - 1)) begin
                        col <= '0;
                        row <= row + coord_t'(1);
                    end else begin
                        col <= col + coord_t'(1);
                    end
                end
                // Last window closes before it is emitted
                default: begin
                    out_idx <= out_idx + 3'd1;
                    if (out_idx == 3'(N_MAX - 1)) begin
                        state <= POOL_IDLE;
                    end
                end
            endcase
        end
    end

    // Running maxima, channel major
    always_ff @(posedge clk) begin
        if (d_vld) begin
            for (int o = 0; o < OUT_CH; o++) begin
                if (win_first || fm.rd_data[o] > maxv[o * WIN_PER_CH + int'(win_sel)]) begin
                    maxv[o * WIN_PER_CH + int'(win_sel)] <= fm.rd_data[o];
                end
            end
        end
    end

    // Finished maps only while the previous set is out
    assert property (@(posedge clk) disable iff (!rst_n)
        fm.filled |-> state == POOL_IDLE)
        else $error("feature maps filled while pooling was still busy");

endmodule

`default_nettype wire

// File: test/cnn_testdata.txt
// mode seed pixel_fill kernel_fill fixed_flag fixed_value (hex)
// fill 80 draws LFSR values, seed 0 uses the default, value is 20-bit two's complement
1 00000000 03 02 1 00048
0 00000000 03 02 1 00048
0 00000000 03 fe 1 fffee
1 00000000 03 fe 1 fffb8
1 00000000 fb 07 1 ffe5c
0 00000000 81 81 1 2f40c
1 00000000 80 80 0 00000
0 00000000 80 80 0 00000
1 1234abcd 80 80 0 00000
0 5a5a1c3e 80 80 0 00000
1 00c3a7e1 80 05 0 00000
0 6d2b19f4 80 fd 0 00000
1 00000001 7f 80 0 00000
0 9e3779b9 80 80 0 00000

// File: test/tb_cnn.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cnn import cnn_pkg::*; ();

    localparam int          CLK_PERIOD    = 10;
    localparam int          RESET_CYCLES  = 16;
    localparam int          IDLE_CYCLES   = 20;
    localparam int          JOB_CYCLES    = 300;
    localparam int          MARGIN_CYCLES = 200;
    localparam int          OUT_TIMEOUT   = 400;
    localparam int          MAX_TESTS     = 32;
    localparam int          N_OUT         = OUT_CH * POOL_DIM * POOL_DIM;
    localparam logic [31:0] DEFAULT_SEED  = 32'hf1e;
    localparam logic [31:0] LFSR_POLY     = 32'h8020_0003;
    localparam string       DATA_FILE     = "test/cnn_testdata.txt";

    logic clk;
    logic rst_n;
    logic in_valid;
    pix_t img;
    pix_t kernel_ch1;
    pix_t kernel_ch2;
    logic opt;
    logic out_valid;
    acc_t out;

    // Test table from the data file
    logic [31:0] tc_mode   [MAX_TESTS];
    logic [31:0] tc_seed   [MAX_TESTS];
    logic [31:0] tc_pfill  [MAX_TESTS];
    logic [31:0] tc_kfill  [MAX_TESTS];
    logic [31:0] tc_fixed  [MAX_TESTS];
    logic [31:0] tc_expect [MAX_TESTS];
    int          num_tests;
    logic        tests_ready;

    logic [31:0] lfsr_state;
    pix_t        img_data [IN_CH][IMG_DIM][IMG_DIM];
    pix_t        ker_data [OUT_CH][IN_CH][KER_TAPS];
    acc_t        expected [N_OUT];

    cnn_top #(.PIX_W(8), .ACC_W(20)) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .img        (img),
        .kernel_ch1 (kernel_ch1),
        .kernel_ch2 (kernel_ch2),
        .opt        (opt),
        .out_valid  (out_valid),
        .out        (out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Reporting
    // ====================
    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input acc_t actual, input acc_t want);
        if (actual !== want) begin
            $display("CHECK FAILED %s: actual %h, expected %h", name, actual, want);
            abort_run();
        end
    endtask

    task automatic check_quiet();
        check_value("out_valid", acc_t'(out_valid), '0);
        check_value("out", out, '0);
    endtask

    // ====================
    // Stimulus data
    // ====================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_POLY;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit, 8 bits per value
    task automatic draw_byte(output pix_t value);
        value = '0;
        for (int b = 0; b < 8; b++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic pick_value(input logic [31:0] fill, output pix_t value);
        if (fill[7:0] == 8'h80) begin
            draw_byte(value);
        end else begin
            value = pix_t'(fill[7:0]);
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_mode;
        logic [31:0] f_seed;
        logic [31:0] f_pfill;
        logic [31:0] f_kfill;
        logic [31:0] f_fixed;
        logic [31:0] f_expect;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test data file %s", DATA_FILE);
            abort_run();
        end
        num_tests = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Comment and blank lines do not scan as six fields
            n = $sscanf(line, "%h %h %h %h %h %h", f_mode, f_seed, f_pfill, f_kfill,
                        f_fixed, f_expect);
            if (n == 6) begin
                if (num_tests == MAX_TESTS) begin
                    $display("Too many tests in %s", DATA_FILE);
                    abort_run();
                end
                tc_mode[num_tests]   = f_mode;
                tc_seed[num_tests]   = f_seed;
                tc_pfill[num_tests]  = f_pfill;
                tc_kfill[num_tests]  = f_kfill;
                tc_fixed[num_tests]  = f_fixed;
                tc_expect[num_tests] = f_expect;
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("No tests found in %s", DATA_FILE);
            abort_run();
        end
    endtask

    task automatic prepare_job(input int t);
        lfsr_state = (tc_seed[t] == 32'd0) ? DEFAULT_SEED : tc_seed[t];
        for (int ch = 0; ch < IN_CH; ch++) begin
            for (int r = 0; r < IMG_DIM; r++) begin
                for (int c = 0; c < IMG_DIM; c++) begin
                    pick_value(tc_pfill[t], img_data[ch][r][c]);
                end
            end
        end
        for (int o = 0; o < OUT_CH; o++) begin
            for (int ch = 0; ch < IN_CH; ch++) begin
                for (int k = 0; k < KER_TAPS; k++) begin
                    pick_value(tc_kfill[t], ker_data[o][ch][k]);
                end
            end
        end
    endtask

    // ====================
    // Reference model
    // ====================
    function automatic int padded_pixel(input int ch, input int r, input int c,
                                        input logic mode);
        int ir;
        int ic;
        ir = r - 1;
        ic = c - 1;
        if (ir < 0 || ir >= IMG_DIM || ic < 0 || ic >= IMG_DIM) begin
            if (!mode) begin
                return 0;
            end
            // Replicate takes the nearest edge pixel
            if (ir < 0) ir = 0;
            if (ir > IMG_DIM - 1) ir = IMG_DIM - 1;
            if (ic < 0) ic = 0;
            if (ic > IMG_DIM - 1) ic = IMG_DIM - 1;
        end
        return int'(img_data[ch][ir][ic]);
    endfunction

    task automatic predict_outputs(input logic mode);
        int conv [OUT_CH][CONV_DIM][CONV_DIM];
        int best;
        int idx;
        for (int o = 0; o < OUT_CH; o++) begin
            for (int r = 0; r < CONV_DIM; r++) begin
                for (int c = 0; c < CONV_DIM; c++) begin
                    conv[o][r][c] = 0;
                    for (int ch = 0; ch < IN_CH; ch++) begin
                        for (int k = 0; k < KER_TAPS; k++) begin
                            conv[o][r][c] += padded_pixel(ch, r + k / KER_DIM,
                                c + k % KER_DIM, mode) * int'(ker_data[o][ch][k]);
                        end
                    end
                end
            end
        end
        // Channel major, windows in row-major order
        idx = 0;
        for (int o = 0; o < OUT_CH; o++) begin
            for (int wr = 0; wr < POOL_DIM; wr++) begin
                for (int wc = 0; wc < POOL_DIM; wc++) begin
                    best = conv[o][wr * POOL_WIN][wc * POOL_WIN];
                    for (int r = 0; r < POOL_WIN; r++) begin
                        for (int c = 0; c < POOL_WIN; c++) begin
                            if (conv[o][wr * POOL_WIN + r][wc * POOL_WIN + c] > best) begin
                                best = conv[o][wr * POOL_WIN + r][wc * POOL_WIN + c];
                            end
                        end
                    end
                    expected[idx] = acc_t'(best);
                    idx++;
                end
            end
        end
    endtask

    // ====================
    // Job sequence
    // ====================
    task automatic drive_burst(input logic mode);
        for (int cyc = 0; cyc < LOAD_CYCLES; cyc++) begin
            check_quiet();
            in_valid = 1'b1;
            img = img_data[cyc / PIX_PER_CH][(cyc % PIX_PER_CH) / IMG_DIM][cyc % IMG_DIM];
            // Opt only counts on the first beat
            opt = (cyc == 0) ? mode : !mode;
            if (cyc < KER_CYCLES) begin
                kernel_ch1 = ker_data[0][cyc / KER_TAPS][cyc % KER_TAPS];
                kernel_ch2 = ker_data[1][cyc / KER_TAPS][cyc % KER_TAPS];
            end else begin
                kernel_ch1 = '0;
                kernel_ch2 = '0;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        img = '0;
        kernel_ch1 = '0;
        kernel_ch2 = '0;
        opt = 1'b0;
    endtask

    task automatic collect_outputs(input int t);
        int wait_cycles;
        wait_cycles = 0;
        while (out_valid !== 1'b1) begin
            check_value("out", out, '0);
            if (wait_cycles == OUT_TIMEOUT) begin
                $display("No out_valid within %0d cycles of the input burst", OUT_TIMEOUT);
                abort_run();
            end
            wait_cycles++;
            @(negedge clk);
        end
        for (int k = 0; k < N_OUT; k++) begin
            check_value($sformatf("out_valid[%0d]", k), acc_t'(out_valid), acc_t'(1));
            check_value($sformatf("out[%0d]", k), out, expected[k]);
            if (tc_fixed[t][0]) begin
                check_value($sformatf("out[%0d] fixed", k), out, acc_t'(tc_expect[t]));
            end
            @(negedge clk);
        end
        // Exactly eight beats, then quiet
        check_quiet();
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        img = '0;
        kernel_ch1 = '0;
        kernel_ch2 = '0;
        opt = 1'b0;
        tests_ready = 1'b0;
        load_tests();
        tests_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            check_quiet();
            @(negedge clk);
        end
        // Each job starts on the cycle after the previous job's last output
        for (int t = 0; t < num_tests; t++) begin
            prepare_job(t);
            predict_outputs(tc_mode[t][0]);
            drive_burst(tc_mode[t][0]);
            collect_outputs(t);
        end
        $display("** PASS **");
        $finish;
    end

    // Watchdog
    initial begin
        int limit;
        wait (tests_ready);
        limit = num_tests * JOB_CYCLES + RESET_CYCLES + IDLE_CYCLES + MARGIN_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        abort_run();
    end

endmodule

`default_nettype wire
